/* Makefile */
# Verilator flow for the trigger capture testbench

TOP := trig_capture_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* list.f */
+incdir+logic
+incdir+test
logic/trig_capture_pkg.sv
logic/trigger_extract.sv
logic/sample_delay.sv
logic/capture_control.sv
logic/trig_capture_top.sv
test/trig_capture_tb.sv

/* logic/capture_control.sv */
// Arm and trigger FSM that forwards one fixed-length sample burst; used by the top level
`timescale 1ns/1ps
`include "trig_capture_settings.svh"

module capture_control
  import trig_capture_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     arm,
  input  logic [`TC_BUS_WIDTH-1:0] in_data,
  input  logic                     in_valid,
  input  logic                     in_trig,
  output logic [`TC_BUS_WIDTH-1:0] capture_data,
  output logic                     capture_valid,
  output logic                     capture_done,
  output logic                     busy
);

  localparam int LEN   = `TC_CAPTURE_LEN;
  localparam int CNT_W = $clog2(LEN + 1);

  cap_state_e       state;
  logic [CNT_W-1:0] count;

  // High once the burst holds all its samples
  logic burst_full;

  // High on a strobe that becomes an output sample
  logic take;

  // Output sample register, one lane per channel
  sample_word_u [`TC_CHANNELS-1:0] burst_q;

  assign burst_full = (count == CNT_W'(LEN));

  // The triggering sample itself is the first one forwarded
  // Later strobes are taken until the burst is full, their trigger flags ignored
  assign take = in_valid &&
                ((state == cap_armed && in_trig) ||
                 (state == cap_burst && !burst_full));

  // ************************************************************
  // State machine
  // ************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= cap_idle;
      count         <= '0;
      capture_valid <= 1'b0;
      capture_done  <= 1'b0;
    end else begin
      // Output strobe follows the taken input strobe by one cycle
      capture_valid <= take;
      capture_done  <= 1'b0;
      case (state)
        cap_idle: begin
          // Arm is only honoured here, elsewhere it is dropped
          if (arm) begin
            state <= cap_armed;
          end
        end
        cap_armed: begin
          if (take) begin
            state <= cap_burst;
            count <= CNT_W'(1);
          end
        end
        cap_burst: begin
          // The full test runs one cycle after the last sample was taken
          // So done lands right after the last capture_valid
          if (burst_full) begin
            state        <= cap_idle;
            count        <= '0;
            capture_done <= 1'b1;
          end else if (take) begin
            count <= count + 1'b1;
          end
        end
        default: begin
          state <= cap_idle;
        end
      endcase
    end
  end

  // ************************************************************
  // Sample register and outputs
  // ************************************************************

  always_ff @(posedge clk) begin
    if (take) begin
      burst_q <= in_data;
    end
  end

  assign capture_data = burst_q;

  // Busy covers both waiting for a trigger and the burst itself
  assign busy = (state != cap_idle);

  // ************************************************************
  // Checks
  // ************************************************************

  // Every output sample comes from a delayed input strobe and belongs to a burst
  a_valid_in_burst: assert property (
    @(posedge clk) disable iff (rst)
    capture_valid |-> $past(in_valid) && state == cap_burst
  ) else $error("capture_valid outside a burst, state %s", state.name());

  a_count_range: assert property (
    @(posedge clk) disable iff (rst)
    count <= CNT_W'(LEN)
  ) else $error("burst counter overran, count %0d", count);

  // The extractor guarantees sign extension through the whole delay path
  genvar c;
  generate
    for (c = 0; c < `TC_CHANNELS; c = c + 1) begin : g_chk
      a_lane_extended: assert property (
        @(posedge clk) disable iff (rst)
        capture_valid |-> burst_q[c].sample[15] == burst_q[c].sample[14]
      ) else $error("channel %0d captured without sign extension", c);
    end
  endgenerate

endmodule

/* logic/sample_delay.sv */
// Strobe-driven delay line for the extended sample bus; used by the top level between extractor and controller
`timescale 1ns/1ps

module sample_delay #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid
);

  // Enough bits to count up to DEPTH-1 strobes
  localparam int FILL_W = $clog2(DEPTH + 1);

  // Delay stages, stage 0 takes the newest sample
  logic [WIDTH-1:0] stage [DEPTH];

  // Strobes seen since reset, saturating once the line holds real data
  logic [FILL_W-1:0] fill;
  logic              filled;

  // With DEPTH-1 strobes behind us the last stage holds a real sample on the next shift
  assign filled = (fill == FILL_W'(DEPTH - 1));

  // ************************************************************
  // Data path
  // ************************************************************

  always_ff @(posedge clk) begin
    if (in_valid) begin
      stage[0] <= in_data;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // After the strobe of sample k this holds sample k-(DEPTH-1)
  assign out_data = stage[DEPTH-1];

  // ************************************************************
  // Fill tracking and output strobe
  // ************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      fill      <= '0;
      out_valid <= 1'b0;
    end else begin
      // One output strobe per input strobe, once the line is primed
      out_valid <= in_valid && filled;
      if (in_valid && !filled) begin
        fill <= fill + 1'b1;
      end
    end
  end

  // Back-to-back outputs need back-to-back inputs one cycle earlier
  a_no_extra_strobe: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && $past(out_valid) |-> $past(in_valid) && $past(in_valid, 2)
  ) else $error("sample_delay produced a strobe without a matching input");

endmodule

/* logic/trig_capture_pkg.sv */
// Shared types for the trigger capture design; import into any RTL module or testbench using them
package trig_capture_pkg;

  // ************************************************************
  // Converter word views
  // ************************************************************

  // Raw converter lane as delivered by the ADC
  // The top bit marks a trigger and the rest is a 15-bit signed value
  typedef struct packed {
    logic        trig;
    logic [14:0] value;
  } tag_word_t;

  // One 16-bit lane seen two ways
  // The extractor reads the tag view, everything downstream reads the sample view
  typedef union packed {
    tag_word_t          tag;
    logic signed [15:0] sample;
  } sample_word_u;

  // ************************************************************
  // Capture controller states
  // ************************************************************

  // Idle waits for arm, armed waits for a trigger, burst forwards samples
  typedef enum logic [1:0] {
    cap_idle  = 2'd0,
    cap_armed = 2'd1,
    cap_burst = 2'd2
  } cap_state_e;

endpackage

/* logic/trig_capture_settings.svh */
// Sizing defines for the trigger capture design; include in any file needing these counts
`ifndef TRIG_CAPTURE_SETTINGS_SVH
`define TRIG_CAPTURE_SETTINGS_SVH

// Number of converter channels on the input bus, at most 16
`define TC_CHANNELS 4

// Strobes of delay in the sample path
// The trigger path reproduces exactly this delay
`define TC_DELAY_DEPTH 2

// Samples forwarded per burst, the triggered one included
`define TC_CAPTURE_LEN 8

// Each channel occupies one 16-bit lane of the bus
`define TC_BUS_WIDTH (`TC_CHANNELS * 16)

`endif

/* logic/trig_capture_top.sv */
// Top level of the trigger capture subsystem; instantiate as the DUT or inside a larger ADC design
`timescale 1ns/1ps
`include "trig_capture_settings.svh"

module trig_capture_top
  import trig_capture_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`TC_BUS_WIDTH-1:0] data_in,
  input  logic                     data_valid,
  input  logic                     arm,
  output logic [`TC_BUS_WIDTH-1:0] capture_data,
  output logic                     capture_valid,
  output logic                     capture_done,
  output logic                     busy
);

  // ************************************************************
  // Internal buses
  // ************************************************************

  // Sign-extended samples straight from the extractor
  sample_word_u [`TC_CHANNELS-1:0] ext_data;

  // Same samples after the fixed strobe delay
  sample_word_u [`TC_CHANNELS-1:0] dly_data;
  logic                            dly_valid;

  // Combined trigger, already lined up with dly_data
  logic trig_aligned;

  // ************************************************************
  // Trigger extraction
  // ************************************************************

  trigger_extract #(
    .CHANNELS (`TC_CHANNELS)
  ) i_extract (
    .clk          (clk),
    .rst          (rst),
    .data_in      (data_in),
    .data_valid   (data_valid),
    .ext_data     (ext_data),
    .trig_aligned (trig_aligned)
  );

  // ************************************************************
  // Sample path
  // ************************************************************

  // The trigger path in the extractor compensates exactly this depth
  sample_delay #(
    .WIDTH (`TC_BUS_WIDTH),
    .DEPTH (`TC_DELAY_DEPTH)
  ) i_delay (
    .clk       (clk),
    .rst       (rst),
    .in_data   (ext_data),
    .in_valid  (data_valid),
    .out_data  (dly_data),
    .out_valid (dly_valid)
  );

  // ************************************************************
  // Capture control
  // ************************************************************

  capture_control i_control (
    .clk           (clk),
    .rst           (rst),
    .arm           (arm),
    .in_data       (dly_data),
    .in_valid      (dly_valid),
    .in_trig       (trig_aligned),
    .capture_data  (capture_data),
    .capture_valid (capture_valid),
    .capture_done  (capture_done),
    .busy          (busy)
  );

endmodule

/* logic/trigger_extract.sv */
// Splits trigger flags off the converter words and delays the combined trigger; used by the top level
`timescale 1ns/1ps
`include "trig_capture_settings.svh"

module trigger_extract
  import trig_capture_pkg::*;
#(
  parameter int CHANNELS = `TC_CHANNELS
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [CHANNELS*16-1:0]  data_in,
  input  logic                    data_valid,
  output logic [CHANNELS*16-1:0]  ext_data,
  output logic                    trig_aligned
);

  // Matches the depth of the sample delay line
  localparam int DEPTH = `TC_DELAY_DEPTH;

  // Per-lane views of the input and the rebuilt output
  sample_word_u [CHANNELS-1:0] word_in;
  sample_word_u [CHANNELS-1:0] word_ext;

  // One trigger flag per channel
  logic [CHANNELS-1:0] flags;
  logic                any_trig;

  // Trigger shift register, one stage per strobe of sample delay
  logic [DEPTH-1:0] trig_sr;

  assign word_in = data_in;

  // ************************************************************
  // Flag extraction and sign extension
  // ************************************************************

  genvar n;
  generate
    for (n = 0; n < CHANNELS; n = n + 1) begin : g_lane
      // The flag bit is replaced by a copy of the sign bit of the 15-bit value
      assign word_ext[n].sample = {word_in[n].tag.value[14], word_in[n].tag.value};
      assign flags[n] = word_in[n].tag.trig;
    end
  endgenerate

  // Sample words leave with no latency
  assign ext_data = word_ext;

  // Any flagged channel triggers the whole word
  assign any_trig = |flags;

  // ************************************************************
  // Trigger delay compensation
  // ************************************************************

  // Shifts only on strobes so the trigger tracks the same sample as the delay line
  // After sample k is strobed the last stage holds the trigger of sample k-(DEPTH-1)
  always_ff @(posedge clk) begin
    if (rst) begin
      trig_sr <= '0;
    end else if (data_valid) begin
      trig_sr[0] <= any_trig;
      for (int i = 1; i < DEPTH; i++) begin
        trig_sr[i] <= trig_sr[i-1];
      end
    end
  end

  assign trig_aligned = trig_sr[DEPTH-1];

  // ************************************************************
  // Checks
  // ************************************************************

  // The subsystem is sized for at most 16 converter channels
  a_channel_limit: assert property (@(posedge clk) CHANNELS <= 16)
    else $error("trigger_extract supports at most 16 channels, got %0d", CHANNELS);

endmodule

/* test/trig_capture_ref.svh */
// Random source, reference model and compare tasks; included inside the testbench module

// Galois LFSR state, stepped once per bit handed out
logic [31:0] lfsr_state = 32'h63ea0d13;

// Returns n fresh random bits in the low end of the word
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_state[0]};
    if (lfsr_state[0]) begin
      lfsr_state = (lfsr_state >> 1) ^ 32'hD0000001;
    end else begin
      lfsr_state = lfsr_state >> 1;
    end
  end
  return r;
endfunction

// ************************************************************
// Reference model
// ************************************************************

// A 15-bit signed value widened to 16 bits, flag bit dropped
function automatic sample_word_u extend_word(input sample_word_u raw);
  sample_word_u e;
  e.sample = $signed({raw.tag.value, 1'b0}) >>> 1;
  return e;
endfunction

function automatic lanes_t extend_lanes(input lanes_t raw);
  lanes_t e;
  for (int c = 0; c < `TC_CHANNELS; c++) begin
    e[c] = extend_word(raw[c]);
  end
  return e;
endfunction

// Any flagged channel counts as a trigger for the whole word
function automatic logic any_flag(input lanes_t raw);
  logic f;
  f = 1'b0;
  for (int c = 0; c < `TC_CHANNELS; c++) begin
    f = f | raw[c].tag.trig;
  end
  return f;
endfunction

// Sample j is judged when strobe j+1 pushes it out of the line
// So it counts only if that strobe lands on or after the arm edge
// Pushes the expected burst and returns the edge of done, or -1 for no burst
function automatic int build_expected(input int arm_edge);
  int first;
  first = -1;
  for (int j = 0; j + 1 < log_bus.size() && first < 0; j++) begin
    if (log_edge[j+1] >= arm_edge && any_flag(log_bus[j])) begin
      first = j;
    end
  end
  if (first < 0 || first + LEN >= log_bus.size()) begin
    return -1;
  end
  for (int j = first; j < first + LEN; j++) begin
    exp_q.push_back(extend_lanes(log_bus[j]));
  end
  return log_edge[first + LEN] + 2;
endfunction

// ************************************************************
// Compare tasks
// ************************************************************

task automatic check_sample(input lanes_t got, input lanes_t exp);
  for (int c = 0; c < `TC_CHANNELS; c++) begin
    if (got[c].sample !== exp[c].sample) begin
      $display("CHECK FAILED at %0t: channel %0d sample %0d, expected %0d",
               $time, c, got[c].sample, exp[c].sample);
      errors++;
    end
  end
endtask

task automatic check_count(input string what, input int got, input int exp);
  if (got !== exp) begin
    $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    errors++;
  end
endtask

/* test/trig_capture_tb.sv */
// Self-checking testbench for the trigger capture top level; run it as the simulation top
`timescale 1ns/1ps
`include "trig_capture_settings.svh"

module trig_capture_tb
  import trig_capture_pkg::*;
();

  localparam int LEN = `TC_CAPTURE_LEN;
  localparam int STROBES = 24;
  localparam int NUM_TESTS = 8 + `TC_CHANNELS;
  // Worst case is every strobe after three idle cycles, plus the settle wait
  localparam int TEST_CYCLES = STROBES * 4 + 70;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES * 2 + 200;

  typedef sample_word_u [`TC_CHANNELS-1:0] lanes_t;

  logic                     clk;
  logic                     rst;
  logic [`TC_BUS_WIDTH-1:0] data_in;
  logic                     data_valid;
  logic                     arm;
  logic [`TC_BUS_WIDTH-1:0] capture_data;
  logic                     capture_valid;
  logic                     capture_done;
  logic                     busy;
  lanes_t                   cap_words;

  int edge_count = 0;
  int errors = 0;
  int dones = 0;
  int got_samples = 0;
  int tests_failed = 0;

  // Clock edge on which the current test expects capture_done
  int exp_done_edge = -1;

  // Every strobe since the last reset with the clock edge that sampled it
  lanes_t log_bus[$];
  int     log_edge[$];
  lanes_t exp_q[$];

  `include "trig_capture_ref.svh"

  trig_capture_top UUT (
    .clk           (clk),
    .rst           (rst),
    .data_in       (data_in),
    .data_valid    (data_valid),
    .arm           (arm),
    .capture_data  (capture_data),
    .capture_valid (capture_valid),
    .capture_done  (capture_done),
    .busy          (busy)
  );

  assign cap_words = capture_data;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    edge_count <= edge_count + 1;
  end

  initial begin
    #(WATCHDOG_CYCLES * 4);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  // ************************************************************
  // Output checking
  // ************************************************************

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (capture_valid) begin
      got_samples++;
      // Every output sample belongs to a burst, so busy must still be high
      check_count("busy during burst", int'(busy), 1);
      if (exp_q.size() == 0) begin
        $display("Unexpected capture_valid at %0t with no sample expected, state %s",
                 $time, UUT.i_control.state.name());
        errors++;
      end else begin
        check_sample(cap_words, exp_q.pop_front());
      end
    end
    if (capture_done) begin
      dones++;
      // Done follows the last output by one cycle and the controller is idle again
      check_count("done edge", edge_count, exp_done_edge);
      check_count("busy at done", int'(busy), 0);
    end
  end

  // ************************************************************
  // Stimulus
  // ************************************************************

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    data_valid = 1'b0;
    arm = 1'b0;
    repeat (8) @(negedge clk);
    log_bus.delete();
    log_edge.delete();
    exp_q.delete();
    rst = 1'b0;
  endtask

  // Drives one strobe schedule and checks the burst it should produce
  // A cut above zero stops after that many strobes and skips the end checks
  task automatic run_test(input string name, input int gap_max, input int trig_at,
                          input int trig_ch, input bit do_arm, input bit noisy,
                          input bit rearm, input int cut);
    lanes_t words [STROBES];
    int     gaps [STROBES];
    int     base;
    int     last_edge;
    int     arm_edge;
    int     done_edge;
    int     rearm_edge;
    int     idx0;
    int     sent;
    int     exp_len;
    int     err0;
    err0 = errors;
    dones = 0;
    got_samples = 0;
    for (int i = 0; i < STROBES; i++) begin
      gaps[i] = int'(rand_bits(2)) % (gap_max + 1);
      for (int c = 0; c < `TC_CHANNELS; c++) begin
        words[i][c].tag.value = 15'(rand_bits(15));
        // Noise flags only fall inside the burst, where they must be ignored
        words[i][c].tag.trig = (i == trig_at && (trig_ch < 0 || trig_ch == c)) ||
                               (noisy && i > trig_at && i < trig_at + LEN &&
                                rand_bits(2) == 0) ||
                               (rearm && i == STROBES - 4);
      end
    end
    @(negedge clk);
    base = edge_count;
    last_edge = base;
    idx0 = log_edge.size();
    for (int i = 0; i < STROBES; i++) begin
      last_edge = last_edge + gaps[i] + 1;
      log_bus.push_back(words[i]);
      log_edge.push_back(last_edge);
    end
    arm_edge = do_arm ? base + 1 : 32'h7fffffff;
    done_edge = build_expected(arm_edge);
    exp_done_edge = done_edge;
    exp_len = exp_q.size();
    // An arm well inside the burst, which the controller has to drop
    rearm_edge = rearm ? done_edge - 4 : -1;
    sent = 0;
    for (int t = base + 1; t <= last_edge && !(cut > 0 && sent >= cut); t++) begin
      arm = (t == arm_edge) || (t == rearm_edge);
      data_valid = (sent < STROBES) && (log_edge[idx0 + sent] == t);
      if (data_valid) begin
        data_in = words[sent];
        sent++;
      end
      @(negedge clk);
      // The accepted arm moves the controller out of idle
      if (t == arm_edge) begin
        check_count("busy after arm", int'(busy), 1);
      end
    end
    data_valid = 1'b0;
    arm = 1'b0;
    if (cut == 0) begin
      if (exp_len > 0) begin
        for (int k = 0; k < 60 && dones == 0; k++) begin
          @(posedge clk);
        end
        if (dones == 0) begin
          $display("Timed out waiting for capture_done in test %s", name);
        end
      end
      repeat (20) @(posedge clk);
      @(negedge clk);
      #1;
      check_count("done pulses", dones, exp_len > 0 ? 1 : 0);
      check_count("captured samples", got_samples, exp_len);
      check_count("pending samples", exp_q.size(), 0);
      check_count("busy after test", int'(busy), 0);
    end
    if (errors == err0) begin
      $display("test %-26s ok", name);
    end else begin
      tests_failed++;
      $display("test %-26s FAILED with %0d errors", name, errors - err0);
    end
  endtask

  initial begin
    rst = 1'b1;
    arm = 1'b0;
    data_valid = 1'b0;
    data_in = '0;
    apply_reset();
    run_test("back-to-back all flags", 0, 3, -1, 1'b1, 1'b1, 1'b0, 0);
    run_test("random gaps", 3, 5, 2, 1'b1, 1'b1, 1'b0, 0);
    for (int c = 0; c < `TC_CHANNELS; c++) begin
      run_test($sformatf("single channel %0d", c), 1, 2, c, 1'b1, 1'b0, 1'b0, 0);
    end
    run_test("triggers without arm", 1, 2, -1, 1'b0, 1'b0, 1'b0, 0);
    run_test("arm during burst", 2, 4, 1, 1'b1, 1'b1, 1'b1, 0);
    run_test("new arm after done", 0, 6, 3, 1'b1, 1'b0, 1'b0, 0);
    run_test("reset mid burst", 0, 2, 0, 1'b1, 1'b0, 1'b0, 6);
    apply_reset();
    run_test("no output after reset", 1, 1, -1, 1'b0, 1'b0, 1'b0, 0);
    apply_reset();
    run_test("trigger on first sample", 0, 0, 1, 1'b1, 1'b0, 1'b0, 0);
    $display("tests %0d, failed %0d, check errors %0d", NUM_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
